//--- cmd_params.svh
`ifndef CMD_PARAMS_SVH
`define CMD_PARAMS_SVH

// FIFO address width. Depth is 2**FIFO_ADDR_W words.
`define FIFO_ADDR_W 4

// One command word per FIFO entry.
`define FIFO_DATA_W 16

// Width of each working register in the execute stage.
`define REG_W 8

// Flops in each pointer synchronizer chain.
`define SYNC_STAGES 2

`endif

//--- cmd_pkg.sv
package cmd_pkg;

    // Opcode field of a command word. Codes above OP_OUT are illegal.
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_LDI  = 4'd1,
        OP_ADD  = 4'd2,
        OP_SUB  = 4'd3,
        OP_AND  = 4'd4,
        OP_OR   = 4'd5,
        OP_XOR  = 4'd6,
        OP_ADDI = 4'd7,
        OP_OUT  = 4'd8
    } opcode_e;

    typedef logic [1:0] reg_idx_t;

    // Layout of one 16-bit command word, MSB first.
    typedef struct packed {
        logic [3:0] opcode;
        reg_idx_t   rd;
        reg_idx_t   rs;
        logic [7:0] imm;
    } cmd_fields_t;

    // True when the raw opcode field names a defined command.
    function automatic logic op_legal(input logic [3:0] code);
        return code <= 4'(OP_OUT);
    endfunction

endpackage

//--- exec_pkg.sv
`include "cmd_params.svh"

package exec_pkg;

    // Register contents. Arithmetic wraps at this width.
    typedef logic [`REG_W-1:0] reg_val_t;

    // What the execute stage reports for a command.
    typedef enum logic [1:0] {
        RES_NONE    = 2'd0,     // Command ran, nothing to report.
        RES_OUT     = 2'd1,     // OUT command, value is the register read.
        RES_ILLEGAL = 2'd2
    } res_kind_e;

endpackage

//--- pipe_if.sv
// Decoded command, carried from decode to execute.
interface cmd_if;
    import cmd_pkg::*;

    logic       valid;      // One-cycle strobe per command.
    opcode_e    op;
    reg_idx_t   rd;
    reg_idx_t   rs;
    logic [7:0] imm;
    logic       illegal;

    modport source (output valid, op, rd, rs, imm, illegal);
    modport sink   (input  valid, op, rd, rs, imm, illegal);
endinterface

// Execution result, carried from execute to the output stage.
interface res_if;
    import exec_pkg::*;

    logic      valid;
    res_kind_e kind;
    reg_val_t  value;

    modport source (output valid, kind, value);
    modport sink   (input  valid, kind, value);
endinterface

//--- async_fifo.sv
`include "cmd_params.svh"

module async_fifo #(
    parameter int ADDR_WIDTH  = 4,
    parameter int SYNC_STAGES = 2
) (
    input  logic                    wclk,
    input  logic                    wrst_n,
    input  logic                    w_en,
    input  logic [`FIFO_DATA_W-1:0] w_data,
    output logic                    w_full,

    input  logic                    rclk,
    input  logic                    rrst_n,
    input  logic                    r_en,
    output logic [`FIFO_DATA_W-1:0] r_data,
    output logic                    r_empty,
    output logic                    r_valid
);

    localparam int PTR_W = ADDR_WIDTH + 1;     // One extra bit tells full from empty.
    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [`FIFO_DATA_W-1:0] mem [DEPTH];

    logic [PTR_W-1:0] w_bin;
    logic [PTR_W-1:0] w_gray;
    logic [PTR_W-1:0] w_bin_next;
    logic [PTR_W-1:0] w_gray_next;
    logic [PTR_W-1:0] r_bin;
    logic [PTR_W-1:0] r_gray;
    logic [PTR_W-1:0] r_bin_next;

    logic [PTR_W-1:0] rq_wclk [SYNC_STAGES];   // Read pointer on its way to wclk.
    logic [PTR_W-1:0] wq_rclk [SYNC_STAGES];   // Write pointer on its way to rclk.

    logic w_push;
    logic r_pop;

    function automatic logic [PTR_W-1:0] to_gray(input logic [PTR_W-1:0] b);
        return b ^ (b >> 1);
    endfunction

    assign w_push = w_en && !w_full;
    assign r_pop  = r_en && !r_empty;

    assign w_bin_next  = w_bin + PTR_W'(w_push);
    assign w_gray_next = to_gray(w_bin_next);
    assign r_bin_next  = r_bin + 1'b1;

    always_ff @(posedge wclk or negedge wrst_n) begin
        if (!wrst_n) begin
            w_bin  <= '0;
            w_gray <= '0;
            w_full <= 1'b0;
        end else begin
            w_bin  <= w_bin_next;
            w_gray <= w_gray_next;
            // Full once the pointer after this edge is one lap ahead of the reader.
            w_full <= (w_gray_next == {~rq_wclk[SYNC_STAGES-1][PTR_W-1:PTR_W-2],
                                        rq_wclk[SYNC_STAGES-1][PTR_W-3:0]});
        end
    end

    always_ff @(posedge wclk) begin
        if (w_push)
            mem[w_bin[ADDR_WIDTH-1:0]] <= w_data;
    end

    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            r_bin   <= '0;
            r_gray  <= '0;
            r_valid <= 1'b0;
        end else begin
            r_valid <= r_pop;
            if (r_pop) begin
                r_bin  <= r_bin_next;
                r_gray <= to_gray(r_bin_next);
            end
        end
    end

    always_ff @(posedge rclk) begin
        if (r_pop)
            r_data <= mem[r_bin[ADDR_WIDTH-1:0]];
    end

    assign r_empty = (wq_rclk[SYNC_STAGES-1] == r_gray);

    for (genvar s = 0; s < SYNC_STAGES; s++) begin : g_sync
        always_ff @(posedge wclk or negedge wrst_n) begin
            if (!wrst_n)
                rq_wclk[s] <= '0;
            else
                rq_wclk[s] <= (s == 0) ? r_gray : rq_wclk[(s == 0) ? 0 : s - 1];
        end

        always_ff @(posedge rclk or negedge rrst_n) begin
            if (!rrst_n)
                wq_rclk[s] <= '0;
            else
                wq_rclk[s] <= (s == 0) ? w_gray : wq_rclk[(s == 0) ? 0 : s - 1];
        end
    end

    // A full FIFO must hold its write pointer until the reader frees a slot.
    a_no_push_when_full: assert property (
        @(posedge wclk) disable iff (!wrst_n) w_full |=> $stable(w_bin));

    a_no_valid_after_empty: assert property (
        @(posedge rclk) disable iff (!rrst_n) r_empty |=> !r_valid);

endmodule

//--- cmd_decode.sv
`include "cmd_params.svh"

module cmd_decode (
    input  logic                    rclk,
    input  logic                    rrst_n,
    input  logic [`FIFO_DATA_W-1:0] fifo_data,
    input  logic                    fifo_valid,
    cmd_if.source                   cmd
);

    import cmd_pkg::*;

    cmd_fields_t word;

    assign word = cmd_fields_t'(fifo_data);

    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n)
            cmd.valid <= 1'b0;
        else
            cmd.valid <= fifo_valid;    // One strobe per popped word.
    end

    // Fields only move when a new word arrives, so they hold between strobes.
    always_ff @(posedge rclk) begin
        if (fifo_valid) begin
            cmd.op      <= opcode_e'(word.opcode);
            cmd.rd      <= word.rd;
            cmd.rs      <= word.rs;
            cmd.imm     <= word.imm;
            cmd.illegal <= !op_legal(word.opcode);
        end
    end

    // Decode adds exactly one cycle, so no strobe appears without a word behind it.
    a_valid_follows_word: assert property (
        @(posedge rclk) disable iff (!rrst_n) !fifo_valid |=> !cmd.valid);

endmodule

//--- alu_execute.sv
module alu_execute (
    input  logic  rclk,
    input  logic  rrst_n,
    cmd_if.sink   cmd,
    res_if.source res
);

    import cmd_pkg::*;
    import exec_pkg::*;

    reg_val_t [3:0] regs;
    reg_val_t       op_a;
    reg_val_t       op_b;
    reg_val_t       wr_val;
    logic           wr_en;
    res_kind_e      kind;

    assign op_a = regs[cmd.rd];
    assign op_b = regs[cmd.rs];

    always_comb begin
        wr_en  = 1'b0;
        wr_val = op_a;
        kind   = RES_NONE;
        if (cmd.illegal) begin
            kind = RES_ILLEGAL;
        end else begin
            wr_en = 1'b1;
            case (cmd.op)
                OP_LDI:  wr_val = cmd.imm;
                OP_ADD:  wr_val = op_a + op_b;      // Wraps modulo 256.
                OP_SUB:  wr_val = op_a - op_b;
                OP_AND:  wr_val = op_a & op_b;
                OP_OR:   wr_val = op_a | op_b;
                OP_XOR:  wr_val = op_a ^ op_b;
                OP_ADDI: wr_val = op_a + cmd.imm;
                OP_OUT: begin
                    wr_en = 1'b0;
                    kind  = RES_OUT;
                end
                default: wr_en = 1'b0;
            endcase
        end
    end

    // The next command reads the register file after this edge,
    // so back-to-back dependencies resolve without a bypass.
    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            regs      <= '0;
            res.valid <= 1'b0;
        end else begin
            res.valid <= cmd.valid;
            if (cmd.valid && wr_en)
                regs[cmd.rd] <= wr_val;
        end
    end

    always_ff @(posedge rclk) begin
        if (cmd.valid) begin
            res.kind  <= kind;
            res.value <= op_b;      // OUT reports register rs.
        end
    end

    a_illegal_keeps_regs: assert property (
        @(posedge rclk) disable iff (!rrst_n)
        (cmd.valid && cmd.illegal) |=> $stable(regs));

endmodule

//--- result_stage.sv
module result_stage (
    input  logic              rclk,
    input  logic              rrst_n,
    res_if.sink               res,
    output logic              out_valid,
    output exec_pkg::reg_val_t out_data,
    output logic [7:0]        out_seq,
    output logic              illegal
);

    import exec_pkg::*;

    logic [7:0] seq_cnt;    // Sequence number of the next OUT.
    logic       is_out;

    assign is_out = res.valid && (res.kind == RES_OUT);

    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            out_valid <= 1'b0;
            illegal   <= 1'b0;
            out_data  <= '0;
            out_seq   <= '0;
            seq_cnt   <= '0;
        end else begin
            out_valid <= is_out;
            illegal   <= res.valid && (res.kind == RES_ILLEGAL);
            if (is_out) begin
                out_data <= res.value;
                out_seq  <= seq_cnt;
                seq_cnt  <= seq_cnt + 1'b1;     // Wraps at 256.
            end
        end
    end

    a_one_strobe: assert property (
        @(posedge rclk) disable iff (!rrst_n) !(out_valid && illegal));

endmodule

//--- cmd_proc_top.sv
`include "cmd_params.svh"

module cmd_proc_top (
    input  logic                    wclk,
    input  logic                    wrst_n,
    input  logic                    w_en,
    input  logic [`FIFO_DATA_W-1:0] w_data,
    output logic                    w_full,

    input  logic                    rclk,
    input  logic                    rrst_n,
    input  logic                    run,
    output logic                    out_valid,
    output exec_pkg::reg_val_t      out_data,
    output logic [7:0]              out_seq,
    output logic                    illegal
);

    logic [`FIFO_DATA_W-1:0] fifo_data;
    logic                    fifo_valid;

    cmd_if cmd_bus ();
    res_if res_bus ();

    // Run gates the read side. Words wait in the FIFO while it is low.
    async_fifo #(
        .ADDR_WIDTH  (`FIFO_ADDR_W),
        .SYNC_STAGES (`SYNC_STAGES)
    ) u_fifo (
        .wclk    (wclk),
        .wrst_n  (wrst_n),
        .w_en    (w_en),
        .w_data  (w_data),
        .w_full  (w_full),
        .rclk    (rclk),
        .rrst_n  (rrst_n),
        .r_en    (run),
        .r_data  (fifo_data),
        .r_empty (),
        .r_valid (fifo_valid)
    );

    cmd_decode u_decode (
        .rclk       (rclk),
        .rrst_n     (rrst_n),
        .fifo_data  (fifo_data),
        .fifo_valid (fifo_valid),
        .cmd        (cmd_bus.source)
    );

    alu_execute u_execute (
        .rclk   (rclk),
        .rrst_n (rrst_n),
        .cmd    (cmd_bus.sink),
        .res    (res_bus.source)
    );

    result_stage u_result (
        .rclk      (rclk),
        .rrst_n    (rrst_n),
        .res       (res_bus.sink),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_seq   (out_seq),
        .illegal   (illegal)
    );

endmodule

//--- tb_cmd_proc.sv
`include "cmd_params.svh"

module tb_cmd_proc;

    timeunit 1ns;
    timeprecision 1ps;

    import cmd_pkg::*;

    localparam int NUM_ROWS   = 13;
    localparam int NUM_RANDOM = 48;
    localparam int NUM_PAUSES = 64;
    localparam int WAIT_LIMIT = 2000;
    localparam int FILL_WORDS = 1 << `FIFO_ADDR_W;

    logic                    wclk;
    logic                    wrst_n;
    logic                    w_en;
    logic [`FIFO_DATA_W-1:0] w_data;
    logic                    w_full;
    logic                    rclk;
    logic                    rrst_n;
    logic                    run;
    logic                    out_valid;
    logic [`REG_W-1:0]       out_data;
    logic [7:0]              out_seq;
    logic                    illegal;

    string                   row_name [NUM_ROWS];
    logic [`FIFO_DATA_W-1:0] row_word [NUM_ROWS];
    logic [`REG_W-1:0]       row_exp  [NUM_ROWS];

    logic [`REG_W-1:0]       model_regs [4];
    logic [`REG_W-1:0]       exp_q [$];         // OUT values still to come, oldest first.
    int                      illegal_exp;
    int                      illegal_seen;
    logic [7:0]              seq_exp;

    logic [`FIFO_DATA_W-1:0] rand_word [NUM_RANDOM];
    int                      rand_gap  [NUM_RANDOM];
    logic                    pause_val [NUM_PAUSES];
    int                      pause_len [NUM_PAUSES];
    logic [31:0]             rng;
    logic                    random_done;

    int    errors;
    int    tests_passed;
    int    tests_failed;
    string cur_test;

    cmd_proc_top DUT (
        .wclk      (wclk),
        .wrst_n    (wrst_n),
        .w_en      (w_en),
        .w_data    (w_data),
        .w_full    (w_full),
        .rclk      (rclk),
        .rrst_n    (rrst_n),
        .run       (run),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_seq   (out_seq),
        .illegal   (illegal)
    );

    initial begin
        rclk = 1'b0;
        forever #5 rclk = ~rclk;
    end

    initial begin
        wclk = 1'b0;
        forever #7 wclk = ~wclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic [15:0] out_word(input logic [1:0] r);
        return {OP_OUT, 2'b00, r, 8'h00};     // OUT reads register rs.
    endfunction

    function automatic void set_row(input int idx, input string name,
                                    input logic [15:0] word, input logic [7:0] exp_val);
        row_name[idx] = name;
        row_word[idx] = word;
        row_exp[idx]  = exp_val;
    endfunction

    // Each command is followed by an OUT of its rd, and the value is what that OUT shows.
    function automatic void fill_table();
        set_row(0,  "ldi_r0",    16'h105A, 8'h5A);
        set_row(1,  "ldi_r1",    16'h14C3, 8'hC3);
        set_row(2,  "add_wrap",  16'h2100, 8'h1D);    // 0x5A + 0xC3 wraps.
        set_row(3,  "sub",       16'h3400, 8'hA6);
        set_row(4,  "and",       16'h4400, 8'h04);
        set_row(5,  "ldi_r2",    16'h18F0, 8'hF0);
        set_row(6,  "or",        16'h5800, 8'hFD);
        set_row(7,  "xor",       16'h6900, 8'hF9);
        set_row(8,  "addi",      16'h7C7F, 8'h7F);
        set_row(9,  "addi_wrap", 16'h7C90, 8'h0F);
        set_row(10, "sub_wrap",  16'h3E00, 8'h16);
        set_row(11, "illegal",   16'hBC55, 8'h16);    // r3 keeps its value.
        set_row(12, "nop",       16'h0012, 8'h1D);
    endfunction

    function automatic void build_random();
        logic [31:0] r;
        logic [3:0]  code;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng  = xorshift32(rng);
            r    = rng;
            code = r[3:0];
            if (code >= 4'd9 && code <= 4'd13)
                code = 4'd8;    // Most spare codes become OUT so more results are seen.
            rand_word[i] = {code, r[11:8], r[23:16]};
            rand_gap[i]  = int'(r[27:26]);
        end
        for (int k = 0; k < NUM_PAUSES; k++) begin
            rng          = xorshift32(rng);
            pause_val[k] = rng[0];
            pause_len[k] = int'(rng[4:2]) + 1;
        end
    endfunction

    // Reference model of the register file.
    function automatic void model_apply(input logic [15:0] word);
        logic [3:0] code;
        logic [1:0] rd;
        logic [1:0] rs;
        logic [7:0] imm;
        code = word[15:12];
        rd   = word[11:10];
        rs   = word[9:8];
        imm  = word[7:0];
        case (code)
            OP_NOP:  begin end
            OP_LDI:  model_regs[rd] = imm;
            OP_ADD:  model_regs[rd] = model_regs[rd] + model_regs[rs];
            OP_SUB:  model_regs[rd] = model_regs[rd] - model_regs[rs];
            OP_AND:  model_regs[rd] = model_regs[rd] & model_regs[rs];
            OP_OR:   model_regs[rd] = model_regs[rd] | model_regs[rs];
            OP_XOR:  model_regs[rd] = model_regs[rd] ^ model_regs[rs];
            OP_ADDI: model_regs[rd] = model_regs[rd] + imm;
            OP_OUT:  exp_q.push_back(model_regs[rs]);
            default: illegal_exp++;
        endcase
    endfunction

    task automatic write_word(input logic [15:0] word, input logic wait_room,
                              output logic stored);
        int waited;
        waited = 0;
        @(negedge wclk);
        while (wait_room && w_full && waited < WAIT_LIMIT) begin
            @(negedge wclk);
            waited++;
        end
        if (wait_room) begin
            assert (!w_full) else begin
                $display("timeout in %s: FIFO stayed full before write of 0x%04h", cur_test, word);
                errors++;
            end
        end
        @(posedge wclk);
        w_en   <= 1'b1;
        w_data <= word;
        @(negedge wclk);
        stored = !w_full;   // The value the FIFO sees at the next edge.
        @(posedge wclk);
        w_en   <= 1'b0;
    endtask

    task automatic set_run(input logic v);
        @(posedge rclk);
        run <= v;
    endtask

    task automatic wait_drain(input string name);
        int waited;
        waited = 0;
        while ((exp_q.size() != 0 || illegal_seen != illegal_exp) && waited < WAIT_LIMIT) begin
            @(negedge rclk);
            waited++;
        end
        assert (exp_q.size() == 0 && illegal_seen == illegal_exp) else begin
            $display("timeout in %s: %0d OUT results and %0d illegal strobes never arrived",
                     name, exp_q.size(), illegal_exp - illegal_seen);
            errors++;
        end
    endtask

    task automatic pause_run();
        int k;
        k = 0;
        while (!random_done && k < NUM_PAUSES) begin
            set_run(pause_val[k]);
            repeat (pause_len[k]) @(posedge rclk);
            k++;
        end
        set_run(1'b1);
    endtask

    task automatic finish_test(input string name, input int err_before);
        if (errors == err_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    // Every strobe is matched in order against what the model predicted.
    initial begin : monitor
        logic [`REG_W-1:0] expected;
        forever begin
            @(negedge rclk);
            if (out_valid) begin
                assert (exp_q.size() > 0) else begin
                    $display("%s: out_valid with data 0x%02h but no OUT was pending",
                             cur_test, out_data);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    expected = exp_q.pop_front();
                    assert (out_data == expected) else begin
                        $display("mismatch %s out_data expected 0x%02h actual 0x%02h",
                                 cur_test, expected, out_data);
                        errors++;
                    end
                end
                assert (out_seq == seq_exp) else begin
                    $display("mismatch %s out_seq expected %0d actual %0d",
                             cur_test, seq_exp, out_seq);
                    errors++;
                end
                seq_exp = seq_exp + 8'd1;
            end
            if (illegal) begin
                assert (illegal_seen < illegal_exp) else begin
                    $display("%s: illegal strobe with no illegal command pending", cur_test);
                    errors++;
                end
                illegal_seen++;
            end
        end
    end

    initial begin : main
        logic        stored;
        logic        seen_full;
        logic [15:0] word;
        int          n_stored;
        int          err_before;
        w_en   = 1'b0;
        w_data = '0;
        run    = 1'b0;
        wrst_n = 1'b0;
        rrst_n = 1'b0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        illegal_exp  = 0;
        illegal_seen = 0;
        seq_exp      = 8'd0;
        cur_test     = "reset";
        for (int r = 0; r < 4; r++)
            model_regs[r] = '0;
        rng = 32'd24;
        fill_table();
        build_random();
        fork
            begin
                repeat (3) @(posedge wclk);
                wrst_n <= 1'b1;
            end
            begin
                repeat (3) @(posedge rclk);
                rrst_n <= 1'b1;
            end
        join
        set_run(1'b1);

        cur_test   = "after_reset";
        err_before = errors;
        repeat (20) begin
            @(negedge wclk);
            assert (!w_full) else begin
                $display("mismatch after_reset w_full expected 0 actual 1");
                errors++;
            end
        end
        finish_test(cur_test, err_before);

        // Run is held low while a row is written, so the command and its OUT issue together.
        for (int i = 0; i < NUM_ROWS; i++) begin
            cur_test   = row_name[i];
            err_before = errors;
            set_run(1'b0);
            write_word(row_word[i], 1'b1, stored);
            if (stored)
                model_apply(row_word[i]);
            word = out_word(row_word[i][11:10]);
            write_word(word, 1'b1, stored);
            if (stored)
                model_apply(word);
            assert (exp_q.size() > 0 && exp_q[$] == row_exp[i]) else begin
                $display("table row %s disagrees with the reference model", cur_test);
                errors++;
            end
            repeat (4) @(posedge rclk);
            set_run(1'b1);
            wait_drain(cur_test);
            finish_test(cur_test, err_before);
        end

        cur_test   = "fifo_full";
        err_before = errors;
        n_stored   = 0;
        seen_full  = 1'b0;
        set_run(1'b0);
        for (int i = 0; i < FILL_WORDS + 3; i++) begin
            if (i % 2 == 0 && i < FILL_WORDS)
                word = {OP_ADDI, 2'd1, 2'd0, 8'(37 * i + 11)};
            else
                word = out_word(2'd1);
            write_word(word, 1'b0, stored);
            assert (!(stored && seen_full)) else begin
                $display("fifo_full: a write was stored after the FIFO reported full");
                errors++;
            end
            if (stored) begin
                model_apply(word);
                n_stored++;
            end else begin
                seen_full = 1'b1;
            end
        end
        @(negedge wclk);
        assert (w_full) else begin
            $display("mismatch fifo_full w_full expected 1 actual 0");
            errors++;
        end
        assert (n_stored == FILL_WORDS) else begin
            $display("mismatch fifo_full stored words expected %0d actual %0d",
                     FILL_WORDS, n_stored);
            errors++;
        end
        set_run(1'b1);
        wait_drain(cur_test);
        finish_test(cur_test, err_before);

        cur_test    = "random";
        err_before  = errors;
        random_done = 1'b0;
        fork
            begin
                for (int i = 0; i < NUM_RANDOM; i++) begin
                    repeat (rand_gap[i]) @(posedge wclk);
                    write_word(rand_word[i], 1'b1, stored);
                    if (stored)
                        model_apply(rand_word[i]);
                end
                random_done = 1'b1;
            end
            pause_run();
        join
        wait_drain(cur_test);
        finish_test(cur_test, err_before);

        // A quiet stretch lets any stray strobe show up before the final count.
        cur_test = "final";
        repeat (30) @(negedge rclk);
        assert (exp_q.size() == 0 && illegal_seen == illegal_exp) else begin
            $display("results left unmatched at the end: %0d OUT pending, illegal %0d of %0d",
                     exp_q.size(), illegal_seen, illegal_exp);
            errors++;
        end
        $display("tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- build.f
+incdir+.
cmd_pkg.sv
exec_pkg.sv
pipe_if.sv
async_fifo.sv
cmd_decode.sv
alu_execute.sv
result_stage.sv
cmd_proc_top.sv
tb_cmd_proc.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module tb_cmd_proc -o sim_cmd_proc

# The run passes only if the testbench printed its pass line.
if ./obj_dir/sim_cmd_proc | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null; then
    exit 0
fi
exit 1
